// File: fcb_pkg.sv
`default_nettype none

package fcb_pkg;

    localparam logic [2:0] REG_CONTROL  = 3'd0;  // Bit 0 program, bit 1 readback, bit 2 clear.
    localparam logic [2:0] REG_DATA     = 3'd1;
    localparam logic [2:0] REG_LENGTH   = 3'd2;  // Bitstream length in bits.
    localparam logic [2:0] REG_EXPECTED = 3'd3;
    localparam logic [2:0] REG_STATUS   = 3'd4;
    localparam logic [2:0] REG_READBACK = 3'd5;
    localparam logic [2:0] REG_CHECKSUM = 3'd6;

    localparam logic [31:0] ADLER_MOD    = 32'd65521;
    localparam logic [15:0] ADLER_INIT_A = 16'd1;

    typedef struct packed {
        logic        prog;  // Program request.
        logic        readback;
        logic        clear;  // One-cycle pulse.
        logic [31:0] length;
        logic [31:0] expected;
    } fcb_ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fcb_word_t;

    // Field order gives word_done at bit 0 and busy at bit 6.
    typedef struct packed {
        logic busy;
        logic overflow;
        logic mismatch;
        logic match;
        logic check_done;
        logic load_done;
        logic word_done;
    } fcb_status_t;

    typedef struct packed {
        logic strobe;  // Readback bit valid on fpga_tail.
        logic last;
    } fcb_bit_t;

endpackage

`default_nettype wire

// File: fcb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fcb_regs import fcb_pkg::*; #(
    parameter int WORD_DEPTH = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    output fcb_ctrl_t   ctrl,
    output fcb_word_t   word,
    input  logic        credit_return,
    input  fcb_status_t status,
    input  logic [31:0] readback_word,
    input  logic [31:0] checksum
);

    localparam int CW = $clog2(WORD_DEPTH + 1);

    logic          req;
    logic          wr;
    logic          issue;
    logic          prog_q;
    logic          readback_q;
    logic          clear_q;
    logic [31:0]   length_q;
    logic [31:0]   expected_q;
    logic          word_valid;
    logic [31:0]   word_data;
    logic [CW-1:0] credits;
    logic          overflow;
    fcb_status_t   status_rd;

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i])
                res[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign wr    = req && wb_we;
    assign issue = wr && (wb_adr == REG_DATA) && (credits != '0);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb_ack     <= 1'b0;
            prog_q     <= 1'b0;
            readback_q <= 1'b0;
            clear_q    <= 1'b0;
            length_q   <= '0;
            expected_q <= '0;
            word_valid <= 1'b0;
            credits    <= CW'(WORD_DEPTH);
            overflow   <= 1'b0;
        end else begin
            wb_ack     <= req;
            clear_q    <= 1'b0;
            word_valid <= issue;
            credits    <= credits + CW'(credit_return) - CW'(issue);
            if (wr && wb_adr == REG_CONTROL && wb_sel[0]) begin
                prog_q     <= wb_dat_i[0];
                readback_q <= wb_dat_i[1];
                clear_q    <= wb_dat_i[2];  // Self-clearing.
            end
            if (wr && wb_adr == REG_LENGTH)
                length_q <= merge_lanes(length_q, wb_dat_i, wb_sel);
            if (wr && wb_adr == REG_EXPECTED)
                expected_q <= merge_lanes(expected_q, wb_dat_i, wb_sel);
            if (wr && wb_adr == REG_DATA && credits == '0)
                overflow <= 1'b1;  // Word dropped.
            if (clear_q) begin
                credits  <= CW'(WORD_DEPTH);  // Shifter flushes its buffer too.
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && wb_adr == REG_DATA)
            word_data <= merge_lanes(word_data, wb_dat_i, wb_sel);
    end

    always_comb begin
        status_rd          = status;
        status_rd.overflow = status.overflow | overflow;
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            case (wb_adr)
                REG_CONTROL:  wb_dat_o <= {30'd0, readback_q, prog_q};
                REG_LENGTH:   wb_dat_o <= length_q;
                REG_EXPECTED: wb_dat_o <= expected_q;
                REG_STATUS:   wb_dat_o <= {25'd0, status_rd};
                REG_READBACK: wb_dat_o <= readback_word;
                REG_CHECKSUM: wb_dat_o <= checksum;
                default:      wb_dat_o <= '0;  // Data port is write-only.
            endcase
        end
    end

    assign ctrl = '{prog: prog_q, readback: readback_q, clear: clear_q,
                    length: length_q, expected: expected_q};
    assign word = '{valid: word_valid, data: word_data};

    assert property (@(posedge clk) disable iff (!reset) credits <= CW'(WORD_DEPTH));

endmodule

`default_nettype wire

// File: fcb_chain_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module fcb_chain_shifter import fcb_pkg::*; #(
    parameter int WORD_DEPTH = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  fcb_ctrl_t   ctrl,
    input  fcb_word_t   word,
    output logic        credit_return,
    input  logic        fpga_tail,
    output logic        fpga_head,
    output logic        prog_clk,
    output logic        config_reset,
    output fcb_bit_t    bit_out,
    output fcb_status_t state_status
);

    localparam int PW = (WORD_DEPTH > 1) ? $clog2(WORD_DEPTH) : 1;
    localparam int CW = $clog2(WORD_DEPTH + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_READ} state_t;

    state_t        state;
    logic [31:0]   mem [WORD_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [31:0]   sh_data;
    logic [31:0]   bit_cnt;  // Bits started so far.
    logic [31:0]   bit_nxt;
    logic [4:0]    wbit;
    logic          active;
    logic          phase;
    logic          word_done_q;
    logic          load_done_q;
    logic          strobe_q;
    logic          last_q;
    logic          rb_go_q;
    logic          empty;
    logic          full;
    logic          push;
    logic          pop;
    logic          bit_end;
    logic          last_bit;
    logic          word_end;
    logic          rb_go;

    assign empty    = (count == '0);
    assign full     = (count == CW'(WORD_DEPTH));
    assign push     = word.valid && !full;
    assign bit_nxt  = bit_cnt + 32'd1;
    assign last_bit = (bit_cnt == ctrl.length);
    assign bit_end  = active && phase;  // End of the prog_clk high cycle.
    assign word_end = (state == ST_LOAD) && bit_end && (wbit == 5'd31 || last_bit);
    assign pop      = (state == ST_LOAD) && !empty && (!active || (word_end && !last_bit));
    assign rb_go    = ctrl.readback && !ctrl.prog;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= word.data;
        if (pop)
            sh_data <= mem[rd_ptr];
        else if (bit_end)
            sh_data <= sh_data << 1;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state         <= ST_IDLE;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            bit_cnt       <= '0;
            wbit          <= '0;
            active        <= 1'b0;
            phase         <= 1'b0;
            fpga_head     <= 1'b0;
            prog_clk      <= 1'b0;
            credit_return <= 1'b0;
            word_done_q   <= 1'b0;
            load_done_q   <= 1'b0;
            strobe_q      <= 1'b0;
            last_q        <= 1'b0;
            rb_go_q       <= 1'b0;
        end else if (ctrl.clear) begin
            state         <= ST_IDLE;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            bit_cnt       <= '0;
            active        <= 1'b0;
            phase         <= 1'b0;
            fpga_head     <= 1'b0;
            prog_clk      <= 1'b0;
            credit_return <= 1'b0;
            word_done_q   <= 1'b0;
            load_done_q   <= 1'b0;  // Raises config_reset again.
            strobe_q      <= 1'b0;
            last_q        <= 1'b0;
            rb_go_q       <= rb_go;
        end else begin
            rb_go_q       <= rb_go;
            credit_return <= 1'b0;
            strobe_q      <= 1'b0;
            last_q        <= 1'b0;
            count         <= count + CW'(push) - CW'(pop);
            if (push)
                wr_ptr <= (wr_ptr == PW'(WORD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(WORD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (active && !phase) begin
                prog_clk <= 1'b1;
                phase    <= 1'b1;
            end
            if (bit_end) begin
                prog_clk <= 1'b0;
                phase    <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                    if (ctrl.prog && !ctrl.readback && !load_done_q && ctrl.length != '0)
                        state <= ST_LOAD;
                    else if (rb_go && !rb_go_q && ctrl.length != '0)
                        state <= ST_READ;
                end
                ST_LOAD: begin
                    if (word_end) begin
                        credit_return <= 1'b1;
                        word_done_q   <= 1'b1;
                    end
                    if (pop) begin
                        fpga_head <= mem[rd_ptr][31];  // MSB first.
                        active    <= 1'b1;
                        wbit      <= '0;
                        bit_cnt   <= bit_nxt;
                        if (!active)
                            word_done_q <= 1'b0;
                    end else if (bit_end) begin
                        if (last_bit) begin
                            active      <= 1'b0;
                            load_done_q <= 1'b1;
                            state       <= ST_IDLE;
                        end else if (wbit == 5'd31) begin
                            active <= 1'b0;  // Stall until the next word.
                        end else begin
                            fpga_head <= sh_data[30];
                            wbit      <= wbit + 5'd1;
                            bit_cnt   <= bit_nxt;
                        end
                    end
                end
                ST_READ: begin
                    if (!active || (bit_end && !last_bit)) begin
                        fpga_head <= fpga_tail;  // Recirculate.
                        strobe_q  <= 1'b1;
                        last_q    <= (bit_nxt == ctrl.length);
                        active    <= 1'b1;
                        bit_cnt   <= bit_nxt;
                    end else if (bit_end) begin
                        active <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign config_reset = !load_done_q;
    assign bit_out      = '{strobe: strobe_q, last: last_q};
    assign state_status = '{word_done: word_done_q, load_done: load_done_q,
                            busy: (state != ST_IDLE), default: 1'b0};

    // Credits from fcb_regs must keep the buffer from overrunning.
    assert property (@(posedge clk) disable iff (!reset) !(word.valid && full));
    assert property (@(posedge clk) disable iff (!reset) prog_clk |=> !prog_clk);

endmodule

`default_nettype wire

// File: fcb_readback_adler.sv
`timescale 1ns/1ps
`default_nettype none

module fcb_readback_adler import fcb_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fcb_ctrl_t   ctrl,
    input  fcb_bit_t    bit_in,
    input  logic        fpga_tail,
    output logic [31:0] readback_word,
    output logic [31:0] checksum,
    output fcb_status_t check_status
);

    logic [15:0] acc_a;
    logic [15:0] acc_b;
    logic [7:0]  byte_q;
    logic [7:0]  byte_next;
    logic [7:0]  fold_byte;
    logic [2:0]  bit_idx;
    logic [16:0] a_sum;
    logic [16:0] b_sum;
    logic [15:0] a_new;
    logic [15:0] b_new;
    logic        rb_go;
    logic        rb_go_q;
    logic        cmp_pend;
    logic        check_done_q;
    logic        match_q;
    logic        mismatch_q;

    assign rb_go     = ctrl.readback && !ctrl.prog;
    assign byte_next = {byte_q[6:0], fpga_tail};
    assign fold_byte = byte_next << (3'd7 - bit_idx);  // Partial byte padded in low bits.

    always_comb begin
        a_sum = {1'b0, acc_a} + {9'd0, fold_byte};
        a_new = (a_sum >= ADLER_MOD) ? 16'(a_sum - ADLER_MOD) : a_sum[15:0];
        b_sum = {1'b0, acc_b} + {1'b0, a_new};
        b_new = (b_sum >= ADLER_MOD) ? 16'(b_sum - ADLER_MOD) : b_sum[15:0];
    end

    always_ff @(posedge clk) begin
        if (bit_in.strobe) begin
            byte_q        <= byte_next;
            readback_word <= {readback_word[30:0], fpga_tail};
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            acc_a        <= ADLER_INIT_A;
            acc_b        <= '0;
            bit_idx      <= '0;
            rb_go_q      <= 1'b0;
            cmp_pend     <= 1'b0;
            check_done_q <= 1'b0;
            match_q      <= 1'b0;
            mismatch_q   <= 1'b0;
        end else begin
            rb_go_q  <= rb_go;
            cmp_pend <= 1'b0;
            if (ctrl.clear || (rb_go && !rb_go_q)) begin
                acc_a        <= ADLER_INIT_A;  // New run.
                acc_b        <= '0;
                bit_idx      <= '0;
                check_done_q <= 1'b0;
                match_q      <= 1'b0;
                mismatch_q   <= 1'b0;
            end else begin
                if (bit_in.strobe) begin
                    bit_idx  <= bit_idx + 3'd1;
                    cmp_pend <= bit_in.last;
                    if (bit_idx == 3'd7 || bit_in.last) begin
                        acc_a   <= a_new;
                        acc_b   <= b_new;
                        bit_idx <= '0;
                    end
                end
                if (cmp_pend) begin
                    check_done_q <= 1'b1;
                    match_q      <= (checksum == ctrl.expected);
                    mismatch_q   <= (checksum != ctrl.expected);
                end
            end
        end
    end

    assign checksum     = {acc_b, acc_a};
    assign check_status = '{check_done: check_done_q, match: match_q,
                            mismatch: mismatch_q, default: 1'b0};

    assert property (@(posedge clk) disable iff (!reset) !(match_q && mismatch_q));

endmodule

`default_nettype wire

// File: fcb_top.sv
`timescale 1ns/1ps
`default_nettype none

module fcb_top import fcb_pkg::*; #(
    parameter int WORD_DEPTH = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [3:0]  wb_sel,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    input  logic        fpga_tail,
    output logic        fpga_head,
    output logic        prog_clk,
    output logic        config_reset
);

    fcb_ctrl_t   ctrl;
    fcb_word_t   word;
    fcb_bit_t    rb_bit;
    fcb_status_t shift_status;
    fcb_status_t check_status;
    fcb_status_t status;
    logic        credit_return;
    logic [31:0] readback_word;
    logic [31:0] checksum;

    assign status = fcb_status_t'(shift_status | check_status);  // Disjoint fields.

    fcb_regs #(.WORD_DEPTH(WORD_DEPTH)) u_regs (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_i,
        .wb_dat_o, .wb_ack, .ctrl, .word, .credit_return, .status,
        .readback_word, .checksum
    );

    fcb_chain_shifter #(.WORD_DEPTH(WORD_DEPTH)) u_shifter (
        .clk, .reset, .ctrl, .word, .credit_return, .fpga_tail, .fpga_head,
        .prog_clk, .config_reset, .bit_out(rb_bit), .state_status(shift_status)
    );

    fcb_readback_adler u_adler (
        .clk, .reset, .ctrl, .bit_in(rb_bit), .fpga_tail, .readback_word,
        .checksum, .check_status
    );

endmodule

`default_nettype wire

// File: tb_config_chain.sv
`timescale 1ns/1ps
`default_nettype none

module tb_config_chain #(
    parameter int CHAIN_LEN = 96
) (
    input  logic prog_clk,
    input  logic fpga_head,
    output logic fpga_tail
);

    logic [CHAIN_LEN-1:0] cells;  // Bit 0 sits next to fpga_head.

    // Configuration cells power up cleared and have no reset of their own.
    initial begin
        cells = '0;
    end

    always @(posedge prog_clk) begin
        cells <= {cells[CHAIN_LEN-2:0], fpga_head};
    end

    assign fpga_tail = cells[CHAIN_LEN-1];

endmodule

`default_nettype wire

// File: tb_fcb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fcb import fcb_pkg::*; ();

    localparam int CHAIN_LEN       = 96;
    localparam int CLK_PERIOD      = 8;
    localparam int POLL_LIMIT      = 200;
    // Three loads and three readbacks at two clk cycles per bit, plus bus traffic.
    localparam int WATCHDOG_CYCLES = 2 * CHAIN_LEN * 6 + 3000;
    localparam int BIT_WORD_DONE   = 0;
    localparam int BIT_CHECK_DONE  = 2;

    logic        clk = 1'b0;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        fpga_tail;
    logic        fpga_head;
    logic        prog_clk;
    logic        config_reset;

    integer               seed = 88196;
    logic [CHAIN_LEN-1:0] chain_model;  // Expected chain contents, bit 0 at fpga_head.
    logic [CHAIN_LEN-1:0] rb_bits;      // Bit i is the i-th bit read back.
    logic [31:0]          stream [3];
    string                test_name = "reset";
    string                name_q [$];
    logic [31:0]          exp_q [$];
    logic [31:0]          act_q [$];
    int                   test_errors;
    int                   error_count;
    int                   tests_run;
    int                   tests_failed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fcb_top #(.WORD_DEPTH(2)) u_dut (
        .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_i,
        .wb_dat_o, .wb_ack, .fpga_tail, .fpga_head, .prog_clk, .config_reset
    );

    tb_config_chain #(.CHAIN_LEN(CHAIN_LEN)) u_chain (.prog_clk, .fpga_head, .fpga_tail);

    // Adler-32 over n bits taken MSB-first into bytes, last byte zero-padded.
    function automatic logic [31:0] adler_ref(input logic [CHAIN_LEN-1:0] bits,
                                              input int n_bits);
        int a;
        int b;
        int byte_val;
        a = 1;
        b = 0;
        for (int k = 0; k < (n_bits + 7) / 8; k++) begin
            byte_val = 0;
            for (int j = 0; j < 8; j++) begin
                byte_val = byte_val * 2;
                if (8 * k + j < n_bits && bits[8 * k + j])
                    byte_val = byte_val + 1;
            end
            a = (a + byte_val) % int'(ADLER_MOD);
            b = (b + a) % int'(ADLER_MOD);
        end
        return {b[15:0], a[15:0]};
    endfunction

    function automatic logic [31:0] last_word(input logic [CHAIN_LEN-1:0] bits,
                                              input int n_bits);
        logic [31:0] w;
        w = '0;
        for (int i = n_bits - 32; i < n_bits; i++)
            w = {w[30:0], bits[i]};
        return w;
    endfunction

    initial begin : compare_proc
        forever begin
            @(negedge clk);
            while (exp_q.size() != 0) begin
                assert (act_q[0] === exp_q[0]) else begin
                    $display("** Error %s: expected %h, actual %h",
                             name_q[0], exp_q[0], act_q[0]);
                    test_errors++;
                    error_count++;
                end
                name_q.delete(0);
                exp_q.delete(0);
                act_q.delete(0);
            end
        end
    end

    task automatic queue_compare(input logic [31:0] expected, input logic [31:0] actual);
        name_q.push_back(test_name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        test_errors++;
        error_count++;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data,
                             input logic [3:0] sel);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_sel   <= sel;
        wb_dat_i <= data;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack)
            report_failure($sformatf("No Wishbone ack for write to register %0d in %s",
                                     adr, test_name));
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        int waited;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack)
            report_failure($sformatf("No Wishbone ack for read of register %0d in %s",
                                     adr, test_name));
        data = wb_dat_o;  // Valid together with the ack.
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic read_status(output fcb_status_t st);
        logic [31:0] d;
        bus_read(REG_STATUS, d);
        st = fcb_status_t'(d[6:0]);
    endtask

    task automatic wait_for_status(input int bit_idx, input string what);
        logic [31:0] d;
        int polls;
        polls = 0;
        do begin
            bus_read(REG_STATUS, d);
            polls++;
        end while (!d[bit_idx] && polls < POLL_LIMIT);
        if (!d[bit_idx])
            report_failure({"Status flag ", what, " never came up in ", test_name});
    endtask

    task automatic load_bitstream(input int n_bits, input bit fresh);
        int shifted;
        shifted = 0;
        for (int w = 0; w < (n_bits + 31) / 32; w++) begin
            if (fresh)
                stream[w] = $random(seed);
            bus_write(REG_DATA, stream[w], 4'hF);
            for (int i = 31; i >= 0; i--) begin
                if (shifted < n_bits) begin
                    chain_model = {chain_model[CHAIN_LEN-2:0], stream[w][i]};  // MSB first.
                    shifted++;
                end
            end
            wait_for_status(BIT_WORD_DONE, "word_done");
        end
    endtask

    // Readback rotates the chain: each tail bit goes back in at the head.
    task automatic model_readback(input int n_bits);
        logic tail;
        rb_bits = '0;
        for (int i = 0; i < n_bits; i++) begin
            tail        = chain_model[CHAIN_LEN-1];
            rb_bits[i]  = tail;
            chain_model = {chain_model[CHAIN_LEN-2:0], tail};
        end
    endtask

    task automatic run_readback();
        bus_write(REG_CONTROL, 32'h2, 4'hF);
        wait_for_status(BIT_CHECK_DONE, "check_done");
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        while (exp_q.size() != 0)
            @(negedge clk);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles while running %s",
                 WATCHDOG_CYCLES, test_name);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        fcb_status_t st;
        logic [31:0] d;
        logic [31:0] ref_sum;
        reset    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_sel   <= '0;
        wb_dat_i <= '0;
        chain_model  = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;

        start_test("register_access");
        @(negedge clk);
        queue_compare(32'd1, 32'(config_reset));  // Held until a bitstream is loaded.
        queue_compare(32'd0, 32'(prog_clk));
        queue_compare(32'd0, 32'(fpga_head));
        queue_compare(32'd0, 32'(wb_ack));
        bus_write(REG_LENGTH, 32'h1122_3344, 4'hF);
        bus_write(REG_EXPECTED, 32'hAABB_CCDD, 4'hF);
        bus_write(REG_LENGTH, 32'h5566_7788, 4'b0101);
        bus_write(REG_EXPECTED, 32'hEEFF_0011, 4'b1010);
        bus_read(REG_LENGTH, d);
        queue_compare(32'h1166_3388, d);
        bus_read(REG_EXPECTED, d);
        queue_compare(32'hEEBB_00DD, d);
        finish_test();

        start_test("load");
        bus_write(REG_LENGTH, CHAIN_LEN, 4'hF);
        bus_write(REG_CONTROL, 32'h1, 4'hF);
        load_bitstream(CHAIN_LEN, 1'b1);
        read_status(st);
        queue_compare(32'd1, 32'(st.load_done));
        @(negedge clk);
        queue_compare(32'd0, 32'(config_reset));
        finish_test();

        start_test("readback_match");
        model_readback(CHAIN_LEN);
        ref_sum = adler_ref(rb_bits, CHAIN_LEN);
        bus_write(REG_EXPECTED, ref_sum, 4'hF);
        run_readback();
        read_status(st);
        queue_compare(32'b011, {29'd0, st.mismatch, st.match, st.check_done});
        bus_read(REG_CHECKSUM, d);
        queue_compare(ref_sum, d);
        bus_read(REG_READBACK, d);
        queue_compare(last_word(rb_bits, CHAIN_LEN), d);
        finish_test();

        start_test("readback_mismatch");
        bus_write(REG_CONTROL, 32'h4, 4'hF);
        bus_write(REG_CONTROL, 32'h1, 4'hF);
        load_bitstream(CHAIN_LEN, 1'b0);
        model_readback(CHAIN_LEN);
        ref_sum = adler_ref(rb_bits, CHAIN_LEN);
        bus_write(REG_EXPECTED, ref_sum ^ 32'h0001_0000, 4'hF);
        run_readback();
        read_status(st);
        queue_compare(32'b101, {29'd0, st.mismatch, st.match, st.check_done});
        finish_test();

        start_test("partial_byte");
        bus_write(REG_CONTROL, 32'h4, 4'hF);
        bus_write(REG_LENGTH, 32'd84, 4'hF);
        bus_write(REG_CONTROL, 32'h1, 4'hF);
        load_bitstream(84, 1'b1);
        model_readback(84);
        ref_sum = adler_ref(rb_bits, 84);
        bus_write(REG_EXPECTED, ref_sum, 4'hF);
        run_readback();
        read_status(st);
        queue_compare(32'b011, {29'd0, st.mismatch, st.match, st.check_done});
        bus_read(REG_CHECKSUM, d);
        queue_compare(ref_sum, d);
        finish_test();

        start_test("overflow");
        bus_write(REG_CONTROL, 32'h4, 4'hF);
        bus_write(REG_CONTROL, 32'h1, 4'hF);
        for (int w = 0; w < 3; w++)
            bus_write(REG_DATA, $random(seed), 4'hF);  // Third word finds no credit.
        read_status(st);
        queue_compare(32'd1, 32'(st.overflow));
        finish_test();

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
fcb_pkg.sv
fcb_regs.sv
fcb_chain_shifter.sv
fcb_readback_adler.sv
fcb_top.sv
tb_config_chain.sv
tb_fcb.sv

// File: Bender.yml
package:
  name: fcb

sources:
  - fcb_pkg.sv
  - fcb_regs.sv
  - fcb_chain_shifter.sv
  - fcb_readback_adler.sv
  - fcb_top.sv
  - target: test
    files:
      - tb_config_chain.sv
      - tb_fcb.sv
